// File: exu_pkg.sv
// execute stage shared definitions
// widths, operation codes and the issue, write-back and jump records
`default_nettype none

package exu_pkg;

    localparam int xlen         = 32;
    localparam int reg_addr_w   = 5;
    localparam int commit_id_w  = 3;

    // write-back flow control
    localparam int wb_credits   = 2;
    localparam int credit_cnt_w = 2;

    // one quotient bit per iteration
    localparam int div_cycles   = 32;
    localparam int div_cnt_w    = $clog2(div_cycles);

    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_bru,
        unit_muldiv
    } exu_unit_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        bru_beq,
        bru_bne,
        bru_blt,
        bru_bge,
        bru_bltu,
        bru_bgeu,
        bru_jal,
        bru_jalr
    } bru_op_e;

    // div group starts at 4, so op[2] marks a divide
    typedef enum logic [2:0] {
        md_mul,
        md_mulh,
        md_mulhsu,
        md_mulhu,
        md_div,
        md_divu,
        md_rem,
        md_remu
    } md_op_e;

    // op is decoded by the target unit
    typedef struct packed {
        logic                   valid;
        exu_unit_e              unit;
        logic [3:0]             op;
        logic [xlen-1:0]        op1;
        logic [xlen-1:0]        op2;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        imm;
        logic [reg_addr_w-1:0]  rd;
        logic [commit_id_w-1:0] commit_id;
    } exu_issue_t;

    typedef struct packed {
        logic                   valid;
        logic [reg_addr_w-1:0]  rd;
        logic [xlen-1:0]        data;
        logic [commit_id_w-1:0] commit_id;
    } exu_wb_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [xlen-1:0] target;
    } exu_jump_t;

endpackage

`default_nettype wire

// File: exu_div.sv
// radix-2 restoring divider on operand magnitudes
// signs and the RISC-V divide-by-zero and overflow results are applied at the output
`default_nettype none

module exu_div import exu_pkg::*; (
    input  wire            clk,
    input  wire            reset_i,
    input  wire            start_i,
    input  wire            signed_i,
    input  wire            rem_i,
    input  wire [xlen-1:0] dividend_i,
    input  wire [xlen-1:0] divisor_i,
    output logic           busy_o,
    output logic           done_o,
    output logic [xlen-1:0] result_o
);

    logic                 dd_neg;
    logic                 dv_neg;
    logic [xlen-1:0]      dd_mag;
    logic [xlen-1:0]      dv_mag;
    logic [xlen:0]        shifted;
    logic [xlen:0]        diff;
    logic                 last;
    logic                 busy_q;
    logic                 done_q;
    logic [div_cnt_w-1:0] cnt_q;
    logic [xlen-1:0]      quo_q;
    logic [xlen-1:0]      rem_q;
    logic [xlen-1:0]      dvs_q;
    logic [xlen-1:0]      dividend_q;
    logic                 rem_sel_q;
    logic                 q_neg_q;
    logic                 r_neg_q;
    logic                 zero_q;
    logic                 ovf_q;
    logic [xlen-1:0]      quo_fix;
    logic [xlen-1:0]      rem_fix;

    assign dd_neg = signed_i && dividend_i[xlen-1];
    assign dv_neg = signed_i && divisor_i[xlen-1];
    assign dd_mag = dd_neg ? -dividend_i : dividend_i;
    assign dv_mag = dv_neg ? -divisor_i : divisor_i;

    // quotient register shifts the dividend bits into the partial remainder
    assign shifted = {rem_q, quo_q[xlen-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign last    = cnt_q == div_cnt_w'(div_cycles - 1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy_q && last;
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (busy_q && last) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q      <= dd_mag;
            rem_q      <= '0;
            dvs_q      <= dv_mag;
            cnt_q      <= '0;
            dividend_q <= dividend_i;
            rem_sel_q  <= rem_i;
            q_neg_q    <= dd_neg ^ dv_neg;
            r_neg_q    <= dd_neg;
            zero_q     <= divisor_i == '0;
            ovf_q      <= signed_i && dividend_i == {1'b1, {(xlen-1){1'b0}}} && divisor_i == '1;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            // borrow means the divisor did not fit, restore
            if (diff[xlen]) begin
                rem_q <= shifted[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b0};
            end else begin
                rem_q <= diff[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b1};
            end
        end
    end

    always_comb begin
        quo_fix = q_neg_q ? -quo_q : quo_q;
        rem_fix = r_neg_q ? -rem_q : rem_q;
        if (zero_q) begin
            result_o = rem_sel_q ? dividend_q : '1;
        end else if (ovf_q) begin
            result_o = rem_sel_q ? '0 : dividend_q;
        end else begin
            result_o = rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

// File: exu_alu.sv
// integer ALU for register and immediate operations
// result, destination and tag wait in a one-entry register for write-back
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   valid_i,
    input  wire alu_op_e          op_i,
    input  wire [xlen-1:0]        op1_i,
    input  wire [xlen-1:0]        op2_i,
    input  wire [reg_addr_w-1:0]  rd_i,
    input  wire [commit_id_w-1:0] commit_id_i,
    output logic                  ready_o,
    output exu_wb_t               res_o,
    input  wire                   pop_i
);

    logic [$clog2(xlen)-1:0] shamt;
    logic [xlen-1:0]         alu_res;
    logic                    accept;
    logic                    valid_q;
    logic [xlen-1:0]         data_q;
    logic [reg_addr_w-1:0]   rd_q;
    logic [commit_id_w-1:0]  cid_q;

    assign shamt = op2_i[$clog2(xlen)-1:0];

    // a popped entry frees the slot in the same cycle
    assign ready_o = !valid_q || pop_i;
    assign accept  = valid_i && ready_o;

    always_comb begin
        case (op_i)
            alu_add:  alu_res = op1_i + op2_i;
            alu_sub:  alu_res = op1_i - op2_i;
            alu_sll:  alu_res = op1_i << shamt;
            alu_slt:  alu_res = xlen'($signed(op1_i) < $signed(op2_i));
            alu_sltu: alu_res = xlen'(op1_i < op2_i);
            alu_xor:  alu_res = op1_i ^ op2_i;
            alu_srl:  alu_res = op1_i >> shamt;
            alu_sra:  alu_res = $signed(op1_i) >>> shamt;
            alu_or:   alu_res = op1_i | op2_i;
            alu_and:  alu_res = op1_i & op2_i;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (pop_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= alu_res;
            rd_q   <= rd_i;
            cid_q  <= commit_id_i;
        end
    end

    assign res_o = '{valid: valid_q, rd: rd_q, data: data_q, commit_id: cid_q};

endmodule

`default_nettype wire

// File: exu_bru.sv
// branch unit, resolves the condition and the jump target
`default_nettype none

module exu_bru import exu_pkg::*; (
    input  wire            clk,
    input  wire            reset_i,
    input  wire            valid_i,
    input  wire bru_op_e   op_i,
    input  wire [xlen-1:0] op1_i,
    input  wire [xlen-1:0] op2_i,
    input  wire [xlen-1:0] pc_i,
    input  wire [xlen-1:0] imm_i,
    output exu_jump_t      jump_o
);

    logic            taken;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] target;
    logic            valid_q;
    logic            taken_q;
    logic [xlen-1:0] target_q;

    always_comb begin
        case (op_i)
            bru_beq:  taken = op1_i == op2_i;
            bru_bne:  taken = op1_i != op2_i;
            bru_blt:  taken = $signed(op1_i) < $signed(op2_i);
            bru_bge:  taken = $signed(op1_i) >= $signed(op2_i);
            bru_bltu: taken = op1_i < op2_i;
            bru_bgeu: taken = op1_i >= op2_i;
            // jal and jalr
            default:  taken = 1'b1;
        endcase
    end

    // jalr drops bit zero of the sum
    assign jalr_sum = op1_i + imm_i;
    assign target   = (op_i == bru_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc_i + imm_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        taken_q  <= taken;
        target_q <= target;
    end

    assign jump_o = '{valid: valid_q, taken: taken_q, target: target_q};

endmodule

`default_nettype wire

// File: exu_muldiv.sv
// multiply/divide unit, one operation in flight at a time
// registered multiplier, iterative divider and a holding register for write-back
`default_nettype none

module exu_muldiv import exu_pkg::*; (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   valid_i,
    input  wire md_op_e           op_i,
    input  wire [xlen-1:0]        op1_i,
    input  wire [xlen-1:0]        op2_i,
    input  wire [reg_addr_w-1:0]  rd_i,
    input  wire [commit_id_w-1:0] commit_id_i,
    output logic                  ready_o,
    output exu_wb_t               res_o,
    input  wire                   pop_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_div,
        st_hold
    } md_state_e;

    md_state_e              state_q;
    logic                   accept;
    logic                   is_div;
    logic                   a_signed;
    logic                   b_signed;
    logic                   div_signed;
    logic                   div_rem;
    logic [xlen:0]          mul_a;
    logic [xlen:0]          mul_b;
    logic signed [2*xlen+1:0] mul_full;
    logic [2*xlen-1:0]      prod_q;
    md_op_e                 op_q;
    logic [xlen-1:0]        data_q;
    logic [reg_addr_w-1:0]  rd_q;
    logic [commit_id_w-1:0] cid_q;
    logic                   div_start;
    logic                   div_busy;
    logic                   div_done;
    logic [xlen-1:0]        div_result;

    assign ready_o = (state_q == st_idle) && !div_busy;
    assign accept  = valid_i && ready_o;

    assign is_div     = op_i inside {md_div, md_divu, md_rem, md_remu};
    assign a_signed   = op_i inside {md_mul, md_mulh, md_mulhsu};
    assign b_signed   = op_i inside {md_mul, md_mulh};
    assign div_signed = op_i inside {md_div, md_rem};
    assign div_rem    = op_i inside {md_rem, md_remu};

    // one extra bit per operand covers signed and unsigned in one multiplier
    assign mul_a    = {a_signed && op1_i[xlen-1], op1_i};
    assign mul_b    = {b_signed && op2_i[xlen-1], op2_i};
    assign mul_full = $signed(mul_a) * $signed(mul_b);

    assign div_start = accept && is_div;

    exu_div u_div (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .rem_i      (div_rem),
        .dividend_i (op1_i),
        .divisor_i  (op2_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (accept) state_q <= is_div ? st_div : st_mul;
                st_mul:  state_q <= st_hold;
                st_div:  if (div_done) state_q <= st_hold;
                default: if (pop_i) state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prod_q <= mul_full[2*xlen-1:0];
            op_q   <= op_i;
            rd_q   <= rd_i;
            cid_q  <= commit_id_i;
        end
        // mul keeps the low word, mulh variants the high word
        if (state_q == st_mul) begin
            data_q <= (op_q == md_mul) ? prod_q[xlen-1:0] : prod_q[2*xlen-1:xlen];
        end else if (state_q == st_div && div_done) begin
            data_q <= div_result;
        end
    end

    assign res_o = '{valid: state_q == st_hold, rd: rd_q, data: data_q, commit_id: cid_q};

endmodule

`default_nettype wire

// File: exu_wb_arb.sv
// write-back arbiter with credit-based flow control
// muldiv wins over the ALU, one result per cycle while credits last
`default_nettype none

module exu_wb_arb import exu_pkg::*; (
    input  wire     clk,
    input  wire     reset_i,
    input  exu_wb_t md_res_i,
    input  exu_wb_t alu_res_i,
    output logic    md_pop_o,
    output logic    alu_pop_o,
    output exu_wb_t wb_o,
    input  wire     credit_i
);

    logic [credit_cnt_w-1:0] credit_cnt_q;
    logic                    has_credit;
    logic                    spend;

    assign has_credit = credit_cnt_q != '0;

    assign md_pop_o  = md_res_i.valid && has_credit;
    assign alu_pop_o = alu_res_i.valid && !md_res_i.valid && has_credit;
    assign spend     = md_pop_o || alu_pop_o;

    // the granted buffer drives the channel directly
    always_comb begin
        wb_o       = md_pop_o ? md_res_i : alu_res_i;
        wb_o.valid = spend;
    end

    // spend and return may coincide and cancel out
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_cnt_q <= credit_cnt_w'(wb_credits);
        end else begin
            credit_cnt_q <= credit_cnt_q + credit_cnt_w'(credit_i) - credit_cnt_w'(spend);
        end
    end

endmodule

`default_nettype wire

// File: exu_top.sv
// integer execute stage top
// steers issued instructions to ALU, branch and muldiv units and merges write-back
`default_nettype none

module exu_top import exu_pkg::*; (
    input  wire             clk,
    input  wire             reset_i,
    input  wire exu_issue_t issue_i,
    output logic            stall_o,
    output exu_wb_t         wb_o,
    input  wire             credit_i,
    output exu_jump_t       jump_o
);

    logic    alu_valid;
    logic    bru_valid;
    logic    md_valid;
    logic    alu_ready;
    logic    md_ready;
    logic    alu_pop;
    logic    md_pop;
    exu_wb_t alu_res;
    exu_wb_t md_res;

    assign alu_valid = issue_i.valid && issue_i.unit == unit_alu;
    assign bru_valid = issue_i.valid && issue_i.unit == unit_bru;
    assign md_valid  = issue_i.valid && issue_i.unit == unit_muldiv;

    // branch and none always go through
    assign stall_o = (alu_valid && !alu_ready) || (md_valid && !md_ready);

    exu_alu u_alu (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (alu_valid),
        .op_i        (alu_op_e'(issue_i.op)),
        .op1_i       (issue_i.op1),
        .op2_i       (issue_i.op2),
        .rd_i        (issue_i.rd),
        .commit_id_i (issue_i.commit_id),
        .ready_o     (alu_ready),
        .res_o       (alu_res),
        .pop_i       (alu_pop)
    );

    exu_bru u_bru (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (bru_valid),
        .op_i    (bru_op_e'(issue_i.op[2:0])),
        .op1_i   (issue_i.op1),
        .op2_i   (issue_i.op2),
        .pc_i    (issue_i.pc),
        .imm_i   (issue_i.imm),
        .jump_o  (jump_o)
    );

    exu_muldiv u_muldiv (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (md_valid),
        .op_i        (md_op_e'(issue_i.op[2:0])),
        .op1_i       (issue_i.op1),
        .op2_i       (issue_i.op2),
        .rd_i        (issue_i.rd),
        .commit_id_i (issue_i.commit_id),
        .ready_o     (md_ready),
        .res_o       (md_res),
        .pop_i       (md_pop)
    );

    exu_wb_arb u_wb_arb (
        .clk       (clk),
        .reset_i   (reset_i),
        .md_res_i  (md_res),
        .alu_res_i (alu_res),
        .md_pop_o  (md_pop),
        .alu_pop_o (alu_pop),
        .wb_o      (wb_o),
        .credit_i  (credit_i)
    );

endmodule

`default_nettype wire

// File: exu_sva.sv
// write-back arbiter checks on the credit count and the pops
`default_nettype none

module exu_wb_arb_sva import exu_pkg::*; (
    input wire                    clk,
    input wire                    reset_i,
    input wire [credit_cnt_w-1:0] credit_cnt_i,
    input wire                    wb_valid_i,
    input wire                    md_pop_i,
    input wire                    alu_pop_i
);

    credit_bound: assert property (@(posedge clk) disable iff (reset_i)
        credit_cnt_i <= credit_cnt_w'(wb_credits))
        else $error("credit count above the reset value");

    // a write-back always spends a held credit
    wb_needs_credit: assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_i |-> credit_cnt_i != '0)
        else $error("write-back issued with no credit left");

    single_pop: assert property (@(posedge clk) disable iff (reset_i)
        !(md_pop_i && alu_pop_i))
        else $error("both result buffers popped in one cycle");

endmodule

bind exu_wb_arb exu_wb_arb_sva u_sva (
    .clk          (clk),
    .reset_i      (reset_i),
    .credit_cnt_i (credit_cnt_q),
    .wb_valid_i   (wb_o.valid),
    .md_pop_i     (md_pop_o),
    .alu_pop_i    (alu_pop_o)
);

`default_nettype wire

// File: tb_exu.sv
// directed testbench for the integer execute stage
// reference models for ALU, branch and muldiv, write-back monitor and credit responder
`default_nettype none

module tb_exu import exu_pkg::*; ();

    localparam int wait_limit = 200;

    logic                   clk;
    logic                   reset_i;
    exu_issue_t             issue;
    logic                   stall;
    exu_wb_t                wb;
    logic                   credit = 1'b0;
    exu_jump_t              jump;

    int                     value_errors = 0;
    int                     timeout_errors = 0;
    int                     last_stalls = 0;
    int                     owed = 0;
    bit                     credit_en = 1'b1;
    logic [commit_id_w-1:0] next_cid = '0;
    exu_wb_t                wb_q[$];
    exu_wb_t                exp_q[$];

    exu_top UUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue),
        .stall_o  (stall),
        .wb_o     (wb),
        .credit_i (credit),
        .jump_o   (jump)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // write-back monitor samples before the edge pops the buffer
    always @(posedge clk) begin
        if (!reset_i && wb.valid) begin
            wb_q.push_back(wb);
            owed = owed + 1;
        end
    end

    // credit responder returns one credit in the cycle after each write-back
    always @(negedge clk) begin
        if (credit_en && owed > 0) begin
            credit = 1'b1;
            owed   = owed - 1;
        end else begin
            credit = 1'b0;
        end
    end

    function automatic logic [xlen-1:0] alu_result(input alu_op_e op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return {31'h0, $signed(a) < $signed(b)};
            alu_sltu: return {31'h0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            // fill the vacated upper bits with the sign
            alu_sra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input bru_op_e op, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (op)
            bru_beq:  return a == b;
            bru_bne:  return a != b;
            bru_blt:  return $signed(a) < $signed(b);
            bru_bge:  return !($signed(a) < $signed(b));
            bru_bltu: return a < b;
            bru_bgeu: return !(a < b);
            default:  return 1'b1;
        endcase
    endfunction

    function automatic logic [xlen-1:0] muldiv_result(input md_op_e op,
                                                      input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        logic        ovf;
        int          sa;
        int          sb;
        int          sq;
        int          sr;
        ea   = (op == md_mulhu) ? {32'h0, a} : {{32{a[31]}}, a};
        eb   = (op == md_mul || op == md_mulh) ? {{32{b[31]}}, b} : {32'h0, b};
        prod = ea * eb;
        ovf  = a == 32'h8000_0000 && b == 32'hffff_ffff;
        sa   = a;
        sb   = b;
        sq   = 0;
        sr   = 0;
        if (b != 0 && !ovf) begin
            sq = sa / sb;
            sr = sa % sb;
        end
        case (op)
            md_mul:                       return prod[31:0];
            md_mulh, md_mulhsu, md_mulhu: return prod[63:32];
            md_div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
            md_divu: return (b == 0) ? 32'hffff_ffff : a / b;
            md_rem:  return (b == 0) ? a : (ovf ? 32'h0 : sr);
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic exu_issue_t pack_issue(input exu_unit_e unit, input logic [3:0] op,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b,
                                              input logic [xlen-1:0] pc,
                                              input logic [xlen-1:0] imm,
                                              input logic [reg_addr_w-1:0] rd,
                                              input logic [commit_id_w-1:0] cid);
        exu_issue_t ins;
        ins.valid     = 1'b1;
        ins.unit      = unit;
        ins.op        = op;
        ins.op1       = a;
        ins.op2       = b;
        ins.pc        = pc;
        ins.imm       = imm;
        ins.rd        = rd;
        ins.commit_id = cid;
        return ins;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        timeout_errors++;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (stall && n < wait_limit) begin
            n++;
            @(posedge clk);
        end
        last_stalls = n;
        if (stall) begin
            note_timeout("issue was never accepted");
        end
    endtask

    task automatic send(input exu_issue_t ins);
        @(negedge clk);
        issue = ins;
        wait_accept();
    endtask

    task automatic idle();
        @(negedge clk);
        issue = '0;
    endtask

    task automatic send_result(input exu_unit_e unit, input logic [3:0] op,
                               input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                               input logic [xlen-1:0] data, output exu_wb_t exp);
        logic [reg_addr_w-1:0] rd;
        rd  = 5'($urandom_range(1, 31));
        exp = '{valid: 1'b1, rd: rd, data: data, commit_id: next_cid};
        send(pack_issue(unit, op, a, b, '0, '0, rd, next_cid));
        next_cid = next_cid + 1'b1;
    endtask

    task automatic issue_alu(input alu_op_e op, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b);
        exu_wb_t e;
        send_result(unit_alu, 4'(op), a, b, alu_result(op, a, b), e);
        exp_q.push_back(e);
    endtask

    task automatic issue_md(input md_op_e op, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] b);
        exu_wb_t e;
        send_result(unit_muldiv, 4'(op), a, b, muldiv_result(op, a, b), e);
        exp_q.push_back(e);
    endtask

    // compares every expected result in order, then looks for strays
    task automatic check_results();
        exu_wb_t e;
        exu_wb_t got;
        int      n;
        @(negedge clk);
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            n = 0;
            while (wb_q.size() == 0 && n < wait_limit) begin
                n++;
                @(negedge clk);
            end
            if (wb_q.size() == 0) begin
                note_timeout("expected write-back did not arrive");
                exp_q.delete();
            end else begin
                got = wb_q.pop_front();
                check("wb_o.data", got.data, e.data);
                check("wb_o.rd", 32'(got.rd), 32'(e.rd));
                check("wb_o.commit_id", 32'(got.commit_id), 32'(e.commit_id));
            end
        end
        repeat (3) @(negedge clk);
        check("extra write-backs", 32'(wb_q.size()), 32'h0);
        wb_q.delete();
    endtask

    task automatic after_reset();
        @(posedge clk);
        check("wb_o.valid", 32'(wb.valid), 32'h0);
        check("jump_o.valid", 32'(jump.valid), 32'h0);
        repeat (10) @(negedge clk);
        check("write-backs without issue", 32'(wb_q.size()), 32'h0);
        // the first muldiv after reset meets an empty unit
        issue_md(md_mul, 32'h3, 32'h5);
        check("stall_o cycles", 32'(last_stalls), 32'h0);
        idle();
        check_results();
    endtask

    task automatic alu_stream();
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int i = 0; i < 40; i++) begin
            op = alu_op_e'($urandom_range(0, 9));
            a  = $urandom;
            b  = $urandom;
            issue_alu(op, a, b);
        end
        idle();
        check_results();
    endtask

    task automatic branch_ops();
        bru_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] target;
        logic            taken;
        for (int k = 0; k < 8; k++) begin
            // equal, signed-less and unsigned-less operand pairs
            for (int p = 0; p < 3; p++) begin
                op  = bru_op_e'(k);
                a   = (p == 0) ? 32'd5 : ((p == 1) ? 32'hffff_fff0 : 32'h10);
                b   = (p == 0) ? 32'd5 : ((p == 1) ? 32'h10 : 32'hffff_fff0);
                pc  = 32'h0000_1000 + 32'(k * 16 + p * 4);
                imm = (p == 2) ? 32'hffff_ff01 : 32'h0000_0103;
                taken  = branch_taken(op, a, b);
                target = (op == bru_jalr) ? ((a + imm) & ~32'h1) : pc + imm;
                send(pack_issue(unit_bru, 4'(op), a, b, pc, imm, '0, '0));
                idle();
                @(posedge clk);
                check("jump_o.valid", 32'(jump.valid), 32'h1);
                check("jump_o.taken", 32'(jump.taken), 32'(taken));
                check("jump_o.target", jump.target, target);
                @(posedge clk);
                check("jump_o.valid", 32'(jump.valid), 32'h0);
            end
        end
    endtask

    task automatic multiply_ops();
        logic [xlen-1:0] corner [5];
        md_op_e          op;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int k = 0; k < 4; k++) begin
            op = md_op_e'(k);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_md(op, corner[i], corner[j]);
                end
            end
            for (int i = 0; i < 4; i++) begin
                issue_md(op, $urandom, $urandom);
            end
        end
        idle();
        check_results();
    endtask

    task automatic divide_ops();
        md_op_e          op;
        exu_wb_t         e_div;
        exu_wb_t         e_alu;
        exu_wb_t         e_md;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int k = 4; k < 8; k++) begin
            op = md_op_e'(k);
            issue_md(op, $urandom, $urandom);
            issue_md(op, $urandom, 32'($urandom_range(1, 255)));
            issue_md(op, 32'h8000_0000 | $urandom, 32'($urandom_range(1, 1000)));
            issue_md(op, $urandom, 32'h0);
            issue_md(op, 32'h8000_0000, 32'hffff_ffff);
        end
        idle();
        check_results();
        // ALU overtakes a divide and the second muldiv waits for the write-back
        a = $urandom;
        b = 32'($urandom_range(1, 4096));
        send_result(unit_muldiv, 4'(md_divu), a, b, muldiv_result(md_divu, a, b), e_div);
        send_result(unit_alu, 4'(alu_add), a, b, alu_result(alu_add, a, b), e_alu);
        check("ALU stall cycles", 32'(last_stalls), 32'h0);
        send_result(unit_muldiv, 4'(md_rem), a, b, muldiv_result(md_rem, a, b), e_md);
        check("second muldiv stalled", 32'(last_stalls > 0), 32'h1);
        idle();
        check("write-backs before second muldiv", 32'(wb_q.size()), 32'h2);
        exp_q.push_back(e_alu);
        exp_q.push_back(e_div);
        exp_q.push_back(e_md);
        check_results();
    endtask

    task automatic credit_backpressure();
        exu_wb_t         e;
        logic [xlen-1:0] a;
        @(posedge clk);
        credit_en = 1'b0;
        for (int i = 0; i < 3; i++) begin
            issue_alu(alu_xor, $urandom, 32'h0f0f_0f0f);
        end
        a = $urandom;
        e = '{valid: 1'b1, rd: 5'd7, data: alu_result(alu_sub, a, 32'd3), commit_id: next_cid};
        @(negedge clk);
        issue    = pack_issue(unit_alu, 4'(alu_sub), a, 32'd3, '0, '0, 5'd7, next_cid);
        next_cid = next_cid + 1'b1;
        repeat (4) @(posedge clk);
        check("stall_o", 32'(stall), 32'h1);
        @(negedge clk);
        check("write-backs without credit", 32'(wb_q.size()), 32'(wb_credits));
        @(posedge clk);
        credit_en = 1'b1;
        wait_accept();
        exp_q.push_back(e);
        idle();
        check_results();
    endtask

    initial begin
        void'($urandom(32'h5a8f));
        issue   = '0;
        reset_i = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        after_reset();
        alu_stream();
        branch_ops();
        multiply_ops();
        divide_ops();
        credit_backpressure();
        $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
exu_pkg.sv
exu_div.sv
exu_alu.sv
exu_bru.sv
exu_muldiv.sv
exu_wb_arb.sv
exu_top.sv
exu_sva.sv
tb_exu.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu -f filelist.f
./obj_dir/Vtb_exu > sim.log 2>&1 || true
cat sim.log
if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1
